/* logic/ooo_defines.svh */
`ifndef OOO_DEFINES_SVH
`define OOO_DEFINES_SVH

// Physical register file size
`define PHYS_REGS 64

// Architectural registers of RV32
`define ARCH_REGS 32

// Instruction queue entries
`define IQ_DEPTH 8

`endif

/* logic/ooo_pkg.sv */
`include "ooo_defines.svh"

package ooo_pkg;

    typedef logic [$clog2(`PHYS_REGS)-1:0] preg_t;   // Physical register number
    typedef logic [$clog2(`ARCH_REGS)-1:0] areg_t;   // Architectural register number
    typedef logic [31:0]                   word_t;
    typedef logic [63:0]                   order_t;  // Program-order number
    typedef logic [5:0]                    rob_idx_t;

    typedef enum logic [1:0] {
        rs_alu,
        rs_mul,
        rs_div,
        rs_br
    } rs_class_e;

    typedef enum logic [6:0] {
        op_reg   = 7'b0110011,
        op_imm   = 7'b0010011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_br    = 7'b1100011,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111
    } opcode_e;

    typedef struct packed {
        word_t inst;
        word_t pc;
    } fetch_t;

    typedef struct packed {
        opcode_e     opcode;
        logic [2:0]  funct3;
        logic [6:0]  funct7;
        areg_t       rd_s;
        areg_t       rs1_s;
        areg_t       rs2_s;
        word_t       i_imm;
        word_t       s_imm;
        word_t       b_imm;
        word_t       u_imm;
        word_t       j_imm;
        word_t       inst;
        word_t       pc;
    } decode_t;

    typedef struct packed {
        decode_t   dec;
        rs_class_e rs_class;
        preg_t     pd;
        logic      has_dest;
        preg_t     ps1;
        logic      ps1_ready;
        preg_t     ps2;
        logic      ps2_ready;
        rob_idx_t  rob_idx;
        order_t    order;
        word_t     pc_next;
    } dispatch_t;

endpackage

/* logic/inst_queue.sv */
`include "ooo_defines.svh"

module inst_queue (
    input  logic            clk,
    input  logic            rst,
    input  logic            push,
    input  ooo_pkg::fetch_t push_data,
    input  logic            deq,
    output ooo_pkg::fetch_t head,
    output logic            empty,
    output logic            full
);

    localparam int PTR_W = $clog2(`IQ_DEPTH);

    ooo_pkg::fetch_t  mem [`IQ_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             push_ok;
    logic             deq_ok;

    assign empty   = (count == '0);
    assign full    = (count == (PTR_W+1)'(`IQ_DEPTH));
    assign push_ok = push && !full;   // Push into a full queue is dropped
    assign deq_ok  = deq && !empty;
    assign head    = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push_ok) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr <= wr_ptr + 1'b1;   // Wraps at power-of-two depth
            end
            if (deq_ok) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push_ok, deq_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Fetch side must respect iq_full
    a_no_push_full: assert property (@(posedge clk) disable iff (rst) !(push && full))
        else $error("inst_queue: push while full, entry dropped");

    // Rename stage must not pop an empty queue
    a_no_deq_empty: assert property (@(posedge clk) disable iff (rst) !(deq && empty))
        else $error("inst_queue: dequeue while empty");

endmodule

/* logic/free_list.sv */
`include "ooo_defines.svh"

module free_list (
    input  logic           clk,
    input  logic           rst,
    input  logic           alloc,
    output ooo_pkg::preg_t free_head,
    output logic           free_empty,
    input  logic           release_valid,
    input  ooo_pkg::preg_t release_preg
);

    localparam int FL_DEPTH = `PHYS_REGS - `ARCH_REGS;
    localparam int PTR_W    = $clog2(FL_DEPTH);

    ooo_pkg::preg_t   mem [FL_DEPTH];
    logic [PTR_W-1:0] head_ptr;
    logic [PTR_W-1:0] tail_ptr;
    logic [PTR_W:0]   count;
    logic             fl_full;

    assign free_empty = (count == '0);
    assign fl_full    = (count == (PTR_W+1)'(FL_DEPTH));
    assign free_head  = mem[head_ptr];

    // Preload with the registers above the architectural ones
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < FL_DEPTH; i++) begin
                mem[i] <= ooo_pkg::preg_t'(`ARCH_REGS + i);
            end
        end else if (release_valid) begin
            mem[tail_ptr] <= release_preg;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head_ptr <= '0;
            tail_ptr <= '0;   // Full list so tail sits on head
            count    <= (PTR_W+1)'(FL_DEPTH);
        end else begin
            if (alloc) begin
                head_ptr <= head_ptr + 1'b1;
            end
            if (release_valid) begin
                tail_ptr <= tail_ptr + 1'b1;
            end
            case ({release_valid, alloc})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_no_alloc_empty: assert property (@(posedge clk) disable iff (rst) alloc |-> !free_empty)
        else $error("free_list: allocation from an empty list");

    // A release with every register already free means a double free upstream
    a_no_release_full: assert property (@(posedge clk) disable iff (rst)
        release_valid |-> !fl_full)
        else $error("free_list: release while full");

endmodule

/* logic/rename_table.sv */
`include "ooo_defines.svh"

module rename_table (
    input  logic           clk,
    input  logic           rst,
    input  ooo_pkg::areg_t rs1_s,
    input  ooo_pkg::areg_t rs2_s,
    output ooo_pkg::preg_t ps1,
    output ooo_pkg::preg_t ps2,
    output logic           ps1_ready,
    output logic           ps2_ready,
    input  logic           alloc_we,
    input  ooo_pkg::areg_t alloc_areg,
    input  ooo_pkg::preg_t alloc_preg,
    input  logic           wb_valid,
    input  ooo_pkg::preg_t wb_preg
);

    ooo_pkg::preg_t         map [`ARCH_REGS];
    logic [`ARCH_REGS-1:0]  ready;

    // x0 is hardwired to p0 and always ready
    assign ps1       = (rs1_s == '0) ? '0 : map[rs1_s];
    assign ps2       = (rs2_s == '0) ? '0 : map[rs2_s];
    assign ps1_ready = (rs1_s == '0) ? 1'b1 : ready[rs1_s];
    assign ps2_ready = (rs2_s == '0) ? 1'b1 : ready[rs2_s];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `ARCH_REGS; i++) begin
                map[i] <= ooo_pkg::preg_t'(i);   // Identity mapping
            end
            ready <= '1;
        end else begin
            if (wb_valid) begin
                for (int i = 0; i < `ARCH_REGS; i++) begin
                    if (map[i] == wb_preg) begin
                        ready[i] <= 1'b1;
                    end
                end
            end
            // New mapping wins over a writeback to the old one
            if (alloc_we) begin
                map[alloc_areg]   <= alloc_preg;
                ready[alloc_areg] <= 1'b0;
            end
        end
    end

    // Rename stage never gives x0 a physical register
    a_no_x0_alloc: assert property (@(posedge clk) disable iff (rst)
        alloc_we |-> (alloc_areg != '0))
        else $error("rename_table: allocation for x0");

endmodule

/* logic/rename_dispatch.sv */
module rename_dispatch (
    input  logic                clk,
    input  logic                rst,
    input  ooo_pkg::fetch_t     head,
    input  logic                empty,
    output logic                deq,
    input  ooo_pkg::preg_t      free_head,
    input  logic                free_empty,
    output logic                alloc,
    output ooo_pkg::areg_t      rs1_s,
    output ooo_pkg::areg_t      rs2_s,
    input  ooo_pkg::preg_t      ps1,
    input  ooo_pkg::preg_t      ps2,
    input  logic                ps1_ready,
    input  logic                ps2_ready,
    output logic                alloc_we,
    output ooo_pkg::areg_t      alloc_areg,
    input  logic                rob_full,
    input  ooo_pkg::rob_idx_t   rob_tail,
    input  logic [3:0]          rs_full,
    output logic                dispatch_valid,
    output ooo_pkg::dispatch_t  dispatch
);

    ooo_pkg::decode_t   dec;
    ooo_pkg::rs_class_e rs_class;
    ooo_pkg::dispatch_t pkt;
    ooo_pkg::order_t    order;
    logic               has_dest;
    logic               is_muldiv;

    always_comb begin
        dec.opcode = ooo_pkg::opcode_e'(head.inst[6:0]);
        dec.funct3 = head.inst[14:12];
        dec.funct7 = head.inst[31:25];
        dec.rd_s   = head.inst[11:7];
        dec.rs1_s  = head.inst[19:15];
        dec.rs2_s  = head.inst[24:20];
        dec.i_imm  = {{21{head.inst[31]}}, head.inst[30:20]};
        dec.s_imm  = {{21{head.inst[31]}}, head.inst[30:25], head.inst[11:7]};
        dec.b_imm  = {{20{head.inst[31]}}, head.inst[7], head.inst[30:25],
                      head.inst[11:8], 1'b0};
        dec.u_imm  = {head.inst[31:12], 12'h000};
        dec.j_imm  = {{12{head.inst[31]}}, head.inst[19:12], head.inst[20],
                      head.inst[30:21], 1'b0};
        dec.inst   = head.inst;
        dec.pc     = head.pc;
    end

    // M extension shares op_reg with funct7 = 1
    assign is_muldiv = (dec.opcode == ooo_pkg::op_reg) && (dec.funct7 == 7'b0000001);

    always_comb begin
        if (is_muldiv) begin
            rs_class = dec.funct3[2] ? ooo_pkg::rs_div : ooo_pkg::rs_mul;   // div/rem in upper half
        end else if (dec.opcode inside {ooo_pkg::op_br, ooo_pkg::op_jal, ooo_pkg::op_jalr}) begin
            rs_class = ooo_pkg::rs_br;
        end else begin
            rs_class = ooo_pkg::rs_alu;
        end
    end

    assign has_dest = !(dec.opcode inside {ooo_pkg::op_br, ooo_pkg::op_store})
                      && (dec.rd_s != '0);

    // Stall on any missing resource for this instruction
    assign deq = !empty && !rob_full && !rs_full[rs_class] && (!has_dest || !free_empty);

    assign alloc      = deq && has_dest;
    assign alloc_we   = alloc;
    assign alloc_areg = dec.rd_s;
    assign rs1_s      = dec.rs1_s;
    assign rs2_s      = dec.rs2_s;

    always_comb begin
        pkt.dec       = dec;
        pkt.rs_class  = rs_class;
        pkt.pd        = has_dest ? free_head : '0;
        pkt.has_dest  = has_dest;
        pkt.ps1       = ps1;
        pkt.ps1_ready = ps1_ready;
        pkt.ps2       = ps2;
        pkt.ps2_ready = ps2_ready;
        pkt.rob_idx   = rob_tail;
        pkt.order     = order;
        pkt.pc_next   = head.pc + 32'd4;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dispatch_valid <= 1'b0;
            order          <= '0;
        end else begin
            dispatch_valid <= deq;   // One-cycle strobe per dispatch
            if (deq) begin
                order <= order + 64'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (deq) begin
            dispatch <= pkt;
        end
    end

    // A stalled instruction must stay at the queue head until it leaves
    a_head_stable: assert property (@(posedge clk) disable iff (rst)
        (!empty && !deq) |=> $stable(head))
        else $error("rename_dispatch: queue head changed without a dequeue");

endmodule

/* logic/dispatch_core.sv */
module dispatch_core (
    input  logic                clk,
    input  logic                rst,
    input  logic                fetch_valid,
    input  ooo_pkg::fetch_t     fetch,
    output logic                iq_full,
    input  logic                rob_full,
    input  ooo_pkg::rob_idx_t   rob_tail,
    input  logic [3:0]          rs_full,
    input  logic                wb_valid,
    input  ooo_pkg::preg_t      wb_preg,
    input  logic                free_valid,
    input  ooo_pkg::preg_t      free_preg,
    output logic                dispatch_valid,
    output ooo_pkg::dispatch_t  dispatch
);

    ooo_pkg::fetch_t iq_head;
    logic            iq_empty;
    logic            deq;
    ooo_pkg::preg_t  free_head;
    logic            free_empty;
    logic            alloc;
    logic            alloc_we;
    ooo_pkg::areg_t  alloc_areg;
    ooo_pkg::areg_t  rs1_s;
    ooo_pkg::areg_t  rs2_s;
    ooo_pkg::preg_t  ps1;
    ooo_pkg::preg_t  ps2;
    logic            ps1_ready;
    logic            ps2_ready;

    inst_queue u_iq (
        .clk(clk), .rst(rst),
        .push(fetch_valid), .push_data(fetch),
        .deq(deq), .head(iq_head), .empty(iq_empty), .full(iq_full)
    );

    rename_dispatch u_rd (
        .clk(clk), .rst(rst),
        .head(iq_head), .empty(iq_empty), .deq(deq),
        .free_head(free_head), .free_empty(free_empty), .alloc(alloc),
        .rs1_s(rs1_s), .rs2_s(rs2_s), .ps1(ps1), .ps2(ps2),
        .ps1_ready(ps1_ready), .ps2_ready(ps2_ready),
        .alloc_we(alloc_we), .alloc_areg(alloc_areg),
        .rob_full(rob_full), .rob_tail(rob_tail), .rs_full(rs_full),
        .dispatch_valid(dispatch_valid), .dispatch(dispatch)
    );

    rename_table u_rat (
        .clk(clk), .rst(rst),
        .rs1_s(rs1_s), .rs2_s(rs2_s), .ps1(ps1), .ps2(ps2),
        .ps1_ready(ps1_ready), .ps2_ready(ps2_ready),
        .alloc_we(alloc_we), .alloc_areg(alloc_areg), .alloc_preg(free_head),
        .wb_valid(wb_valid), .wb_preg(wb_preg)
    );

    free_list u_fl (
        .clk(clk), .rst(rst),
        .alloc(alloc), .free_head(free_head), .free_empty(free_empty),
        .release_valid(free_valid), .release_preg(free_preg)
    );

endmodule

/* tests/dispatch_tb.sv */
`include "ooo_defines.svh"

module dispatch_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int INST_BUDGET = 100;   // Upper bound on instructions sent
    localparam int FL_SIZE     = `PHYS_REGS - `ARCH_REGS;

    logic                clk;
    logic                rst;
    logic                fetch_valid;
    ooo_pkg::fetch_t     fetch;
    logic                iq_full;
    logic                rob_full;
    ooo_pkg::rob_idx_t   rob_tail;
    logic [3:0]          rs_full;
    logic                wb_valid;
    ooo_pkg::preg_t      wb_preg;
    logic                free_valid;
    ooo_pkg::preg_t      free_preg;
    logic                dispatch_valid;
    ooo_pkg::dispatch_t  dispatch;

    ooo_pkg::preg_t      map_m [`ARCH_REGS];   // Model rename table
    logic                rdy_m [`ARCH_REGS];
    ooo_pkg::preg_t      free_q [$];           // Model free list
    ooo_pkg::preg_t      retire_q [$];         // Old mappings waiting for commit
    ooo_pkg::fetch_t     exp_q [$];            // Fetched, not yet dispatched
    ooo_pkg::order_t     order_m;
    ooo_pkg::rob_idx_t   tail_prev;
    ooo_pkg::fetch_t     cur_f;
    ooo_pkg::dispatch_t  exp_pkt;

    ooo_pkg::opcode_e op_list [9] = '{ooo_pkg::op_reg, ooo_pkg::op_imm, ooo_pkg::op_load,
        ooo_pkg::op_store, ooo_pkg::op_br, ooo_pkg::op_jal, ooo_pkg::op_jalr,
        ooo_pkg::op_lui, ooo_pkg::op_auipc};

    dispatch_core dut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [255:0] got,
                               input logic [255:0] exp);
        if (got !== exp) begin
            $display("error: time %0t signal %s got %0h expected %0h", $time, name, got, exp);
            $display("sim failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    function automatic ooo_pkg::word_t rand_inst();
        ooo_pkg::word_t w;
        w = $urandom();
        w[6:0] = op_list[$urandom_range(8, 0)];
        if (w[6:0] == ooo_pkg::op_reg) begin
            case ($urandom_range(3, 0))
                0:       w[31:25] = 7'h00;
                1:       w[31:25] = 7'h20;
                default: w[31:25] = 7'h01;   // Mostly M extension
            endcase
        end
        return w;
    endfunction

    function automatic ooo_pkg::word_t enc_r(input logic [6:0] f7, input logic [2:0] f3,
        input ooo_pkg::areg_t rd, input ooo_pkg::areg_t rs1, input ooo_pkg::areg_t rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic ooo_pkg::word_t enc_addi(input ooo_pkg::areg_t rd,
        input ooo_pkg::areg_t rs1, input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    // Expected packet from the RV32 encoding and the model state
    function automatic ooo_pkg::dispatch_t expect_packet(input ooo_pkg::fetch_t f,
                                                         input ooo_pkg::rob_idx_t tail);
        ooo_pkg::dispatch_t p;
        ooo_pkg::word_t     inst;
        inst = f.inst;
        p.dec.opcode = ooo_pkg::opcode_e'(inst[6:0]);
        p.dec.funct3 = inst[14:12];
        p.dec.funct7 = inst[31:25];
        p.dec.rd_s   = inst[11:7];
        p.dec.rs1_s  = inst[19:15];
        p.dec.rs2_s  = inst[24:20];
        p.dec.i_imm  = ooo_pkg::word_t'($signed(inst) >>> 20);
        p.dec.s_imm  = {p.dec.i_imm[31:5], inst[11:7]};
        p.dec.b_imm  = {p.dec.s_imm[31:12], inst[7], p.dec.s_imm[10:1], 1'b0};
        p.dec.u_imm  = inst & 32'hffff_f000;
        p.dec.j_imm  = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
        p.dec.inst   = inst;
        p.dec.pc     = f.pc;
        case (inst[6:0])
            7'b0110011: begin
                if (inst[31:25] == 7'h01) begin
                    p.rs_class = (inst[14:12] < 3'd4) ? ooo_pkg::rs_mul : ooo_pkg::rs_div;
                end else begin
                    p.rs_class = ooo_pkg::rs_alu;
                end
            end
            7'b1100011, 7'b1101111, 7'b1100111: p.rs_class = ooo_pkg::rs_br;
            default: p.rs_class = ooo_pkg::rs_alu;
        endcase
        p.has_dest  = (inst[6:0] != 7'b1100011) && (inst[6:0] != 7'b0100011)
                      && (inst[11:7] != 5'd0);
        p.pd        = p.has_dest ? free_q[0] : '0;
        p.ps1       = (p.dec.rs1_s == 0) ? '0 : map_m[p.dec.rs1_s];
        p.ps1_ready = (p.dec.rs1_s == 0) ? 1'b1 : rdy_m[p.dec.rs1_s];
        p.ps2       = (p.dec.rs2_s == 0) ? '0 : map_m[p.dec.rs2_s];
        p.ps2_ready = (p.dec.rs2_s == 0) ? 1'b1 : rdy_m[p.dec.rs2_s];
        p.rob_idx   = tail;
        p.order     = order_m;
        p.pc_next   = f.pc + 32'd4;
        return p;
    endfunction

    // Compare every dispatch against the model, then advance the model
    always @(negedge clk) begin
        if (rst === 1'b0 && dispatch_valid) begin
            if (exp_q.size() == 0) begin
                $display("dispatch_valid rose with no instruction pending in the model");
                $display("sim failed");
                $fatal(1, "unexpected dispatch");
            end else begin
                cur_f   = exp_q.pop_front();
                exp_pkt = expect_packet(cur_f, tail_prev);
                check_value("dispatch.dec", dispatch.dec, exp_pkt.dec);
                check_value("dispatch.rs_class", dispatch.rs_class, exp_pkt.rs_class);
                check_value("dispatch.has_dest", dispatch.has_dest, exp_pkt.has_dest);
                check_value("dispatch.pd", dispatch.pd, exp_pkt.pd);
                check_value("dispatch.ps1", dispatch.ps1, exp_pkt.ps1);
                check_value("dispatch.ps1_ready", dispatch.ps1_ready, exp_pkt.ps1_ready);
                check_value("dispatch.ps2", dispatch.ps2, exp_pkt.ps2);
                check_value("dispatch.ps2_ready", dispatch.ps2_ready, exp_pkt.ps2_ready);
                check_value("dispatch.rob_idx", dispatch.rob_idx, exp_pkt.rob_idx);
                check_value("dispatch.order", dispatch.order, exp_pkt.order);
                check_value("dispatch.pc_next", dispatch.pc_next, exp_pkt.pc_next);
                if (exp_pkt.has_dest) begin
                    void'(free_q.pop_front());
                    retire_q.push_back(map_m[exp_pkt.dec.rd_s]);
                    map_m[exp_pkt.dec.rd_s] = exp_pkt.pd;
                    rdy_m[exp_pkt.dec.rd_s] = 1'b0;
                end
                order_m++;
            end
        end
        tail_prev = rob_tail;   // Value the next dispatch edge captures
    end

    // One push every other cycle so iq_full is always known before the push edge
    task automatic send(input ooo_pkg::word_t inst);
        ooo_pkg::fetch_t f;
        f.inst = inst;
        f.pc   = $urandom() & 32'hffff_fffc;
        @(negedge clk);
        while (iq_full) @(negedge clk);
        @(posedge clk);
        fetch_valid <= 1'b1;
        fetch       <= f;
        rob_tail    <= ooo_pkg::rob_idx_t'($urandom());
        exp_q.push_back(f);
        @(posedge clk);
        fetch_valid <= 1'b0;
    endtask

    task automatic wb_strobe(input ooo_pkg::preg_t p);
        @(posedge clk);
        wb_valid <= 1'b1;
        wb_preg  <= p;
        @(posedge clk);
        wb_valid <= 1'b0;
        for (int i = 0; i < `ARCH_REGS; i++) begin
            if (map_m[i] == p) rdy_m[i] = 1'b1;
        end
    endtask

    task automatic free_reg(input ooo_pkg::preg_t p);
        @(posedge clk);
        free_valid <= 1'b1;
        free_preg  <= p;
        @(posedge clk);
        free_valid <= 1'b0;
        free_q.push_back(p);
    endtask

    task automatic drain();
        while (exp_q.size() != 0) @(negedge clk);
        repeat (2) @(negedge clk);
    endtask

    task automatic retire_all();
        while (retire_q.size() != 0 && free_q.size() < FL_SIZE) begin
            free_reg(retire_q.pop_front());
        end
    endtask

    initial begin
        ooo_pkg::areg_t rd;
        int             n;
        void'($urandom(20435));
        rst         = 1'b1;
        fetch_valid = 1'b0;
        fetch       = '0;
        rob_full    = 1'b0;
        rob_tail    = '0;
        rs_full     = '0;
        wb_valid    = 1'b0;
        wb_preg     = '0;
        free_valid  = 1'b0;
        free_preg   = '0;
        order_m     = '0;
        for (int i = 0; i < `ARCH_REGS; i++) begin
            map_m[i] = ooo_pkg::preg_t'(i);
            rdy_m[i] = 1'b1;
        end
        for (int i = 0; i < FL_SIZE; i++) free_q.push_back(ooo_pkg::preg_t'(`ARCH_REGS + i));
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        repeat (24) send(rand_inst());
        drain();
        retire_all();

        // Dependent chain held by rob_full, then released back to back
        @(posedge clk) rob_full <= 1'b1;
        send(enc_addi(5, 0, 12'h007));
        send(enc_r(7'h00, 3'd0, 6, 5, 5));
        send(enc_r(7'h01, 3'd0, 7, 6, 5));
        repeat (5) send(rand_inst());
        repeat (10) @(negedge clk);
        check_value("pending while rob_full", exp_q.size(), `IQ_DEPTH);
        check_value("iq_full", iq_full, 1'b1);   // Every queue entry is held
        @(posedge clk) rob_full <= 1'b0;
        drain();
        retire_all();

        // Multiply station full blocks the mul and everything behind it
        @(posedge clk) rs_full[ooo_pkg::rs_mul] <= 1'b1;
        send(enc_addi(9, 1, 12'h0ff));
        send(enc_r(7'h01, 3'd0, 10, 9, 2));
        send(enc_addi(11, 10, 12'h001));
        repeat (10) @(negedge clk);
        check_value("pending while mul station full", exp_q.size(), 2);
        @(posedge clk) rs_full <= '0;
        drain();
        retire_all();

        // Writeback makes a fresh mapping ready for later readers
        send(enc_addi(12, 0, 12'h005));
        send(enc_r(7'h00, 3'd0, 13, 12, 12));
        drain();
        wb_strobe(map_m[12]);
        send(enc_r(7'h00, 3'd0, 14, 12, 13));
        drain();
        repeat (4) wb_strobe(map_m[$urandom_range(31, 1)]);
        repeat (12) send(rand_inst());
        drain();
        retire_all();

        // Use up the free list, then stall until one register comes back
        n = free_q.size();
        for (int i = 0; i < n; i++) begin
            rd = ooo_pkg::areg_t'($urandom_range(31, 1));
            send(enc_addi(rd, rd, 12'h001));
        end
        drain();
        send(enc_addi(3, 3, 12'h001));
        repeat (10) @(negedge clk);
        check_value("pending with free list empty", exp_q.size(), 1);
        free_reg(retire_q.pop_front());
        drain();
        retire_all();

        $display("sim passed");
        $finish;
    end

    initial begin
        repeat (INST_BUDGET * 20 + 200) @(posedge clk);
        $display("timeout: the dispatch stream did not complete within the cycle limit");
        $display("sim failed");
        $fatal(1, "timeout");
    end

endmodule

/* all.f */
+incdir+logic
logic/ooo_pkg.sv
logic/inst_queue.sv
logic/free_list.sv
logic/rename_table.sv
logic/rename_dispatch.sv
logic/dispatch_core.sv
tests/dispatch_tb.sv
